/* link_pkg.sv */
`default_nettype none

package link_pkg;

	//////////////////////////////////////////////////
	// Control characters

	localparam logic [7:0] k28_5 = 8'hbc;	// Comma
	localparam logic [7:0] k27_7 = 8'hfb;	// Start of frame
	localparam logic [7:0] k29_7 = 8'hfd;	// End of frame

	localparam int link_w = 32;	// Four characters per word
	localparam int link_k_w = 4;	// One k flag per character

	// K28.5 D21.5 D0.0 D0.0 with the comma in the least significant lane
	localparam logic [link_w-1:0] idle_word = {8'h00, 8'h00, 8'hb5, k28_5};
	localparam logic [link_k_w-1:0] idle_k = 4'b0001;

	//////////////////////////////////////////////////
	// Frame opcodes

	typedef enum logic [7:0] {
		op_write = 8'h01,
		op_read = 8'h02,
		op_write_ack = 8'h81,	// Responses have bit 7 set
		op_read_data = 8'h82,
		op_nack = 8'hff
	} link_op_t;

	//////////////////////////////////////////////////
	// Frame layout

	// Header is sof, opcode, 16 bit address. Data word has no k flags
	localparam int sof_lsb = 0;	// Start or end char
	localparam int op_lsb = 8;
	localparam int addr_lsb = 16;
	localparam int addr_field_w = 16;
	localparam logic [link_k_w-1:0] frame_k = 4'b0001;	// Header and trailer k flags

endpackage

`default_nettype wire

/* apb_pkg.sv */
`default_nettype none

package apb_pkg;

	// Bus sizes on the management side
	localparam int apb_addr_w = 10;
	localparam int apb_data_w = 32;

	// Outcome of the last transfer
	typedef enum logic [1:0] {
		st_ok,
		st_link_down,	// Refused without sending
		st_timeout,	// Far end silent
		st_nack	// Nack, bad frame or wrong opcode
	} bridge_status_t;

endpackage

`default_nettype wire

/* link_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module link_monitor import link_pkg::*; #(
	parameter int userrdy_delay = 255,
	parameter int idle_run = 16
) (
	input wire rxoutclk,
	input wire rx_reset,
	input wire [link_w-1:0] rx_data,
	input wire [link_k_w-1:0] rx_char_is_k,
	input wire rx_comma_is_aligned,
	output logic link_up
);

	localparam int rdy_w = $clog2(userrdy_delay + 1);
	localparam int run_w = $clog2(idle_run + 1);

	//////////////////////////////////////////////////
	// User ready countdown

	logic [rdy_w-1:0] rdy_count;
	logic user_ready;

	always_ff @(posedge rxoutclk) begin
		if (rx_reset) begin
			rdy_count <= rdy_w'(userrdy_delay);
			user_ready <= 1'b0;
		end else begin
			if (rdy_count != 0)
				rdy_count <= rdy_count - 1'b1;
			if (rdy_count <= 1)	// Last tick of the delay
				user_ready <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Word classification

	logic idle_seen;
	logic hdr_seen;
	logic frame_word;
	logic [1:0] frame_left;	// Data and trailer still to come

	assign idle_seen = rx_comma_is_aligned && rx_data == idle_word && rx_char_is_k == idle_k;
	assign hdr_seen = rx_char_is_k == frame_k && rx_data[sof_lsb +: 8] == k27_7;
	assign frame_word = hdr_seen || frame_left != 0;

	always_ff @(posedge rxoutclk) begin
		if (rx_reset)
			frame_left <= 2'd0;
		else if (frame_left != 0)
			frame_left <= frame_left - 1'b1;
		else if (hdr_seen)
			frame_left <= 2'd2;
	end

	//////////////////////////////////////////////////
	// Link up from a run of aligned idles

	logic [run_w-1:0] run_count;

	always_ff @(posedge rxoutclk) begin
		if (rx_reset || !user_ready || !rx_comma_is_aligned) begin
			link_up <= 1'b0;
			run_count <= '0;
		end else if (link_up) begin
			if (!idle_seen && !frame_word) begin	// Stray word
				link_up <= 1'b0;
				run_count <= '0;
			end
		end else if (idle_seen && frame_left == 0) begin
			if (run_count == run_w'(idle_run - 1))
				link_up <= 1'b1;
			else
				run_count <= run_count + 1'b1;
		end else
			run_count <= '0;	// Anything else restarts the run
	end

endmodule

`default_nettype wire

/* req_framer.sv */
`timescale 1ns/1ns
`default_nettype none

module req_framer import link_pkg::*, apb_pkg::*; (
	input wire rxoutclk,
	input wire rx_reset,

	// Request from the completer
	input wire req_start,
	input wire link_op_t req_op,
	input wire [apb_addr_w-1:0] req_addr,
	input wire [apb_data_w-1:0] req_wdata,

	// To the lane
	output logic [link_w-1:0] tx_data,
	output logic [link_k_w-1:0] tx_char_is_k
);

	typedef enum logic [1:0] {
		fr_idle,
		fr_header,
		fr_data,
		fr_trailer
	} fr_state_t;

	fr_state_t state;

	// Copy of the request
	link_op_t op_q;
	logic [apb_addr_w-1:0] addr_q;
	logic [apb_data_w-1:0] wdata_q;

	//////////////////////////////////////////////////
	// Sequencing

	always_ff @(posedge rxoutclk) begin
		if (rx_reset)
			state <= fr_idle;
		else begin
			case (state)
				fr_idle: begin
					if (req_start)	// Only accepted between frames
						state <= fr_header;
				end
				fr_header: state <= fr_data;
				fr_data: state <= fr_trailer;
				default: state <= fr_idle;
			endcase
		end
	end

	always_ff @(posedge rxoutclk) begin
		if (state == fr_idle && req_start) begin
			op_q <= req_op;
			addr_q <= req_addr;
			wdata_q <= req_wdata;
		end
	end

	//////////////////////////////////////////////////
	// Word mux

	always_comb begin
		tx_data = idle_word;
		tx_char_is_k = idle_k;
		case (state)
			fr_header: begin
				tx_data = '0;
				tx_data[sof_lsb +: 8] = k27_7;
				tx_data[op_lsb +: 8] = op_q;
				tx_data[addr_lsb +: addr_field_w] = addr_field_w'(addr_q);	// Zero padded
				tx_char_is_k = frame_k;
			end
			fr_data: begin
				tx_data = wdata_q;	// Don't care for reads
				tx_char_is_k = '0;
			end
			fr_trailer: begin
				tx_data = '0;
				tx_data[sof_lsb +: 8] = k29_7;
				tx_char_is_k = frame_k;
			end
			default: ;	// Idle word
		endcase
	end

endmodule

`default_nettype wire

/* resp_deframer.sv */
`timescale 1ns/1ns
`default_nettype none

module resp_deframer import link_pkg::*; (
	input wire rxoutclk,
	input wire rx_reset,
	input wire [link_w-1:0] rx_data,
	input wire [link_k_w-1:0] rx_char_is_k,

	// Parsed response
	output logic resp_valid,
	output link_op_t resp_op,
	output logic [link_w-1:0] resp_rdata,
	output logic resp_bad
);

	typedef enum logic [1:0] {
		df_hunt,
		df_data,
		df_trailer
	} df_state_t;

	df_state_t state;

	//////////////////////////////////////////////////
	// Word checks

	logic sof_seen;
	logic eof_ok;
	logic op_known;

	// Any word with a start char in lane 0
	assign sof_seen = rx_char_is_k[0] && rx_data[sof_lsb +: 8] == k27_7;
	assign eof_ok = rx_char_is_k == frame_k && rx_data[sof_lsb +: 8] == k29_7;

	always_comb begin
		case (rx_data[op_lsb +: 8])
			op_write_ack, op_read_data, op_nack: op_known = 1'b1;
			default: op_known = 1'b0;	// Requests are not valid answers
		endcase
	end

	//////////////////////////////////////////////////
	// Parser

	always_ff @(posedge rxoutclk) begin
		if (rx_reset) begin
			state <= df_hunt;
			resp_valid <= 1'b0;
			resp_bad <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			resp_bad <= 1'b0;
			case (state)
				df_hunt: begin
					if (sof_seen) begin
						if (rx_char_is_k != frame_k || !op_known)
							resp_bad <= 1'b1;	// Stay hunting
						else
							state <= df_data;
					end
				end
				df_data: begin
					if (rx_char_is_k != 0) begin	// Data word carries no k
						resp_bad <= 1'b1;
						state <= df_hunt;
					end else
						state <= df_trailer;
				end
				default: begin
					if (eof_ok)
						resp_valid <= 1'b1;
					else
						resp_bad <= 1'b1;	// Missing trailer
					state <= df_hunt;
				end
			endcase
		end
	end

	// Payload captured as it goes by
	always_ff @(posedge rxoutclk) begin
		if (state == df_hunt && sof_seen)
			resp_op <= link_op_t'(rx_data[op_lsb +: 8]);
		if (state == df_data)
			resp_rdata <= rx_data;
	end

endmodule

`default_nettype wire

/* apb_completer.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_completer import link_pkg::*, apb_pkg::*; #(
	parameter int resp_timeout = 512
) (
	input wire rxoutclk,
	input wire rx_reset,

	// APB completer
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [apb_addr_w-1:0] paddr,
	input wire [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// Link side
	input wire link_up,
	input wire resp_valid,
	input wire link_op_t resp_op,
	input wire [apb_data_w-1:0] resp_rdata,
	input wire resp_bad,
	output logic req_start,
	output link_op_t req_op,
	output logic [apb_addr_w-1:0] req_addr,
	output logic [apb_data_w-1:0] req_wdata,
	output bridge_status_t last_status
);

	localparam int tmo_w = $clog2(resp_timeout + 1);

	typedef enum logic [1:0] {
		cs_idle,
		cs_send,
		cs_wait,
		cs_done
	} cs_state_t;

	cs_state_t state;
	logic [tmo_w-1:0] tmo_count;
	link_op_t exp_op;

	assign req_start = state == cs_send;	// One cycle, request held
	assign exp_op = req_op == op_write ? op_write_ack : op_read_data;

	//////////////////////////////////////////////////
	// Transfer FSM

	always_ff @(posedge rxoutclk) begin
		if (rx_reset) begin
			state <= cs_idle;
			pready <= 1'b0;
			pslverr <= 1'b0;
			tmo_count <= '0;
			last_status <= st_ok;
		end else begin
			pready <= 1'b0;
			pslverr <= 1'b0;
			case (state)
				cs_idle: begin
					if (psel && !penable) begin	// Setup phase
						if (link_up)
							state <= cs_send;
						else begin
							pready <= 1'b1;
							pslverr <= 1'b1;
							last_status <= st_link_down;
							state <= cs_done;
						end
					end
				end
				cs_send: begin
					tmo_count <= '0;
					state <= cs_wait;
				end
				cs_wait: begin
					tmo_count <= tmo_count + 1'b1;
					if (resp_valid || resp_bad || !link_up ||
						tmo_count == tmo_w'(resp_timeout - 1)) begin
						pready <= 1'b1;
						state <= cs_done;
						if (resp_valid && resp_op == exp_op)
							last_status <= st_ok;
						else begin
							pslverr <= 1'b1;
							if (resp_valid || resp_bad)	// Nack, mismatch or bad frame
								last_status <= st_nack;
							else if (!link_up)
								last_status <= st_link_down;
							else
								last_status <= st_timeout;
						end
					end
				end
				default: state <= cs_idle;	// Access completes here
			endcase
		end
	end

	// Request and read data registers
	always_ff @(posedge rxoutclk) begin
		if (state == cs_idle && psel && !penable) begin
			req_op <= pwrite ? op_write : op_read;
			req_addr <= paddr;
			req_wdata <= pwdata;
		end
		if (state == cs_wait && resp_valid)
			prdata <= resp_rdata;
	end

endmodule

`default_nettype wire

/* apb_link_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_link_bridge import link_pkg::*, apb_pkg::*; #(
	parameter int userrdy_delay = 255,
	parameter int idle_run = 16,
	parameter int resp_timeout = 512
) (
	input wire rxoutclk,
	input wire rx_reset,

	// Lane receive side
	input wire [link_w-1:0] rx_data,
	input wire [link_k_w-1:0] rx_char_is_k,
	input wire rx_comma_is_aligned,

	// Lane transmit side
	output logic [link_w-1:0] tx_data,
	output logic [link_k_w-1:0] tx_char_is_k,

	// APB completer port
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [apb_addr_w-1:0] paddr,
	input wire [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// Status
	output logic link_up,
	output bridge_status_t last_status
);

	//////////////////////////////////////////////////
	// Internal wires

	wire req_start;
	wire link_op_t req_op;
	wire [apb_addr_w-1:0] req_addr;
	wire [apb_data_w-1:0] req_wdata;
	wire resp_valid;
	wire link_op_t resp_op;
	wire [link_w-1:0] resp_rdata;
	wire resp_bad;

	link_monitor #(
		.userrdy_delay(userrdy_delay),
		.idle_run(idle_run)
	) monitor (
		.rxoutclk(rxoutclk),
		.rx_reset(rx_reset),
		.rx_data(rx_data),
		.rx_char_is_k(rx_char_is_k),
		.rx_comma_is_aligned(rx_comma_is_aligned),
		.link_up(link_up)
	);

	req_framer framer (
		.rxoutclk(rxoutclk),
		.rx_reset(rx_reset),
		.req_start(req_start),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.tx_data(tx_data),
		.tx_char_is_k(tx_char_is_k)
	);

	resp_deframer deframer (
		.rxoutclk(rxoutclk),
		.rx_reset(rx_reset),
		.rx_data(rx_data),
		.rx_char_is_k(rx_char_is_k),
		.resp_valid(resp_valid),
		.resp_op(resp_op),
		.resp_rdata(resp_rdata),
		.resp_bad(resp_bad)
	);

	apb_completer #(
		.resp_timeout(resp_timeout)
	) completer (
		.rxoutclk(rxoutclk),
		.rx_reset(rx_reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.link_up(link_up),
		.resp_valid(resp_valid),
		.resp_op(resp_op),
		.resp_rdata(resp_rdata),
		.resp_bad(resp_bad),
		.req_start(req_start),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.last_status(last_status)
	);

endmodule

`default_nettype wire

/* tb_far_end.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_far_end import link_pkg::*; (
	input wire rxoutclk,
	input wire rx_reset,
	input wire [link_w-1:0] tx_data,	// Request words from the DUT
	input wire [link_k_w-1:0] tx_char_is_k,
	output logic [link_w-1:0] rx_data,	// Answer words to the DUT
	output logic [link_k_w-1:0] rx_char_is_k,
	output logic rx_comma_is_aligned,

	// Test hooks held for a whole transfer
	input wire send_nack,
	input wire send_corrupt,
	input wire stay_silent,
	input wire drop_align,

	// First layout violation seen on tx
	output logic frame_fault,
	output logic [link_w-1:0] fault_data,
	output logic [link_k_w-1:0] fault_k,
	output int frames_seen
);

	typedef enum logic [1:0] {
		ex_hunt,	// Idle or header allowed
		ex_data,
		ex_trailer,
		ex_gap	// Idle required after a trailer
	} ex_state_t;

	ex_state_t state;
	logic [31:0] regs [0:1023];
	logic [7:0] req_op;
	logic [9:0] req_addr;
	logic [31:0] req_data;
	logic [31:0] resp_word;
	logic [1:0] send_step;	// Data then trailer still to send
	logic is_idle;
	logic is_header;
	logic is_trailer;
	logic word_bad;
	logic [7:0] answer_op;

	assign is_idle = tx_data == idle_word && tx_char_is_k == idle_k;
	// Request header with the address zero padded to 16 bits
	assign is_header = tx_char_is_k == frame_k && tx_data[7:0] == k27_7 &&
		(tx_data[15:8] == op_write || tx_data[15:8] == op_read) && tx_data[31:26] == 6'h00;
	assign is_trailer = tx_char_is_k == frame_k && tx_data == {24'h000000, k29_7};
	assign answer_op = send_nack ? op_nack : (req_op == op_write ? op_write_ack : op_read_data);

	always_comb begin
		case (state)
			ex_hunt: word_bad = !is_idle && !is_header;
			ex_data: word_bad = tx_char_is_k != 4'b0000;	// Data word has no k
			ex_trailer: word_bad = !is_trailer;
			default: word_bad = !is_idle;
		endcase
	end

	initial begin
		rx_data = idle_word;
		rx_char_is_k = idle_k;
		rx_comma_is_aligned = 1'b1;
		state = ex_hunt;
		send_step = 2'd0;
		frame_fault = 1'b0;
		frames_seen = 0;
		for (int i = 0; i < 1024; i++)
			regs[i] = {6'h15, i[9:0], 6'h2a, ~i[9:0]};	// Index and its inverse
	end

	//////////////////////////////////////////////////
	// Request parsing and answers

	always @(posedge rxoutclk) begin
		if (rx_reset) begin
			rx_data <= idle_word;
			rx_char_is_k <= idle_k;
			rx_comma_is_aligned <= 1'b1;
			state <= ex_hunt;
			send_step <= 2'd0;
		end else begin
			rx_comma_is_aligned <= !drop_align;
			case (send_step)
				2'd1: begin
					rx_data <= resp_word;
					rx_char_is_k <= 4'b0000;
					send_step <= 2'd2;
				end
				2'd2: begin
					// A comma in place of the end char breaks the trailer
					rx_data <= {24'h000000, (send_corrupt ? k28_5 : k29_7)};
					rx_char_is_k <= frame_k;
					send_step <= 2'd0;
				end
				default: begin
					rx_data <= idle_word;
					rx_char_is_k <= idle_k;
				end
			endcase
			if (word_bad && !frame_fault) begin	// Keep the first one
				frame_fault <= 1'b1;
				fault_data <= tx_data;
				fault_k <= tx_char_is_k;
			end
			case (state)
				ex_hunt: begin
					if (is_header) begin
						req_op <= tx_data[15:8];
						req_addr <= tx_data[25:16];
						state <= ex_data;
					end
				end
				ex_data: begin
					req_data <= tx_data;
					state <= word_bad ? ex_hunt : ex_trailer;
				end
				ex_trailer: begin
					state <= word_bad ? ex_hunt : ex_gap;
					if (!word_bad) begin
						frames_seen <= frames_seen + 1;
						if (req_op == op_write)
							regs[req_addr] <= req_data;
						if (!stay_silent) begin
							// Header wins over the idle word set above
							rx_data <= {6'h00, req_addr, answer_op, k27_7};
							rx_char_is_k <= frame_k;
							resp_word <= req_op == op_write ? req_data : regs[req_addr];
							send_step <= 2'd1;
						end
					end
				end
				default: state <= ex_hunt;	// Gap word checked by word_bad
			endcase
		end
	end

endmodule

`default_nettype wire

/* apb_link_bridge_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_link_bridge_tb import link_pkg::*, apb_pkg::*; ();

	localparam int userrdy_delay = 255;
	localparam int idle_run = 16;
	localparam int resp_timeout = 512;
	localparam int max_cycles = 20000;	// Cycle limit for the whole run
	localparam int n_rw = 64;

	logic rxoutclk;
	logic rx_reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic pready;
	logic pslverr;
	logic link_up;
	bridge_status_t last_status;
	logic [link_w-1:0] tx_data;
	logic [link_k_w-1:0] tx_char_is_k;
	logic [link_w-1:0] rx_data;
	logic [link_k_w-1:0] rx_char_is_k;
	logic rx_comma_is_aligned;

	// Far end hooks and frame check results
	logic send_nack;
	logic send_corrupt;
	logic stay_silent;
	logic drop_align;
	logic frame_fault;
	logic [link_w-1:0] fault_data;
	logic [link_k_w-1:0] fault_k;
	int frames_seen;

	int cycle;
	integer seed;
	logic [apb_data_w-1:0] model [0:1023];	// Expected register contents
	logic [apb_addr_w-1:0] addrs [$];
	logic [apb_addr_w-1:0] addr;
	logic [apb_data_w-1:0] wdata;
	logic [apb_data_w-1:0] rdata;
	logic err;
	int lat;
	int start;
	int expected_frames;

	apb_link_bridge #(
		.userrdy_delay(userrdy_delay),
		.idle_run(idle_run),
		.resp_timeout(resp_timeout)
	) dut (
		.rxoutclk(rxoutclk), .rx_reset(rx_reset),
		.rx_data(rx_data), .rx_char_is_k(rx_char_is_k),
		.rx_comma_is_aligned(rx_comma_is_aligned),
		.tx_data(tx_data), .tx_char_is_k(tx_char_is_k),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.link_up(link_up), .last_status(last_status)
	);

	tb_far_end far_end (
		.rxoutclk(rxoutclk), .rx_reset(rx_reset),
		.tx_data(tx_data), .tx_char_is_k(tx_char_is_k),
		.rx_data(rx_data), .rx_char_is_k(rx_char_is_k),
		.rx_comma_is_aligned(rx_comma_is_aligned),
		.send_nack(send_nack), .send_corrupt(send_corrupt),
		.stay_silent(stay_silent), .drop_align(drop_align),
		.frame_fault(frame_fault), .fault_data(fault_data), .fault_k(fault_k),
		.frames_seen(frames_seen)
	);

	//////////////////////////////////////////////////
	// Clock, cycle limit, reporting

	initial rxoutclk = 1'b0;
	always #10 rxoutclk = ~rxoutclk;	// 20 ns period

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else abort_run($sformatf("[ERROR] %s = 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	always @(posedge rxoutclk) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles)
			abort_run($sformatf("Run did not finish within %0d cycles", max_cycles));
	end

	always @(negedge rxoutclk) begin	// Layout checked on every tx word
		assert (!frame_fault)
		else abort_run($sformatf("[ERROR] tx_data = 0x%08h, tx_char_is_k = 0x%01h breaks the frame",
			fault_data, fault_k));
	end

	//////////////////////////////////////////////////
	// APB master

	task automatic apb_transfer(input logic write, input logic [apb_addr_w-1:0] a,
		input logic [apb_data_w-1:0] d, output logic [apb_data_w-1:0] rd,
		output logic slverr, output int latency);
		int t0;
		@(posedge rxoutclk);	// Setup phase
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= a;
		pwdata <= d;
		@(negedge rxoutclk);
		t0 = cycle;
		@(posedge rxoutclk);
		penable <= 1'b1;	// Access phase
		do @(negedge rxoutclk); while (!pready);
		rd = prdata;
		slverr = pslverr;
		latency = cycle - t0;
		@(posedge rxoutclk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic expect_result(input logic exp_err, input bridge_status_t exp_status);
		check_value("pslverr", 32'(err), 32'(exp_err));
		check_value("last_status", 32'(last_status), 32'(exp_status));
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed = 32'h11d277eb;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rx_reset = 1'b1;
		send_nack = 1'b0;
		send_corrupt = 1'b0;
		stay_silent = 1'b0;
		drop_align = 1'b0;
		expected_frames = 0;
		repeat (10) @(posedge rxoutclk);
		rx_reset <= 1'b0;
		@(negedge rxoutclk);
		start = cycle;

		// Too early so refused without a frame
		apb_transfer(1'b1, 10'h055, 32'hdeadbeef, rdata, err, lat);
		expect_result(1'b1, st_link_down);
		check_value("frames_seen", frames_seen, 0);
		do @(negedge rxoutclk); while (!link_up);
		assert (cycle - start >= userrdy_delay + idle_run)
		else abort_run($sformatf("[ERROR] link_up rose after 0x%0h cycles, expected at least 0x%0h",
			cycle - start, userrdy_delay + idle_run));

		// Random writes, then read back
		for (int i = 0; i < n_rw; i++) begin
			addr = apb_addr_w'($random(seed));
			wdata = $random(seed);
			addrs.push_back(addr);
			model[addr] = wdata;
			apb_transfer(1'b1, addr, wdata, rdata, err, lat);
			expected_frames++;
			expect_result(1'b0, st_ok);
		end
		for (int i = 0; i < n_rw; i++) begin
			apb_transfer(1'b0, addrs[i], '0, rdata, err, lat);
			expected_frames++;
			expect_result(1'b0, st_ok);
			check_value("prdata", rdata, model[addrs[i]]);
		end

		// Nack, then a broken trailer
		@(posedge rxoutclk);
		send_nack <= 1'b1;
		apb_transfer(1'b0, addrs[0], '0, rdata, err, lat);
		expected_frames++;
		expect_result(1'b1, st_nack);
		@(posedge rxoutclk);
		send_nack <= 1'b0;
		send_corrupt <= 1'b1;
		apb_transfer(1'b1, addrs[1], 32'h0badf00d, rdata, err, lat);
		expected_frames++;
		expect_result(1'b1, st_nack);
		model[addrs[1]] = 32'h0badf00d;	// Far end still took the write
		@(posedge rxoutclk);
		send_corrupt <= 1'b0;
		apb_transfer(1'b0, addrs[1], '0, rdata, err, lat);
		expected_frames++;
		expect_result(1'b0, st_ok);
		check_value("prdata", rdata, model[addrs[1]]);

		// Silent far end
		@(posedge rxoutclk);
		stay_silent <= 1'b1;
		apb_transfer(1'b0, addrs[2], '0, rdata, err, lat);
		expected_frames++;
		expect_result(1'b1, st_timeout);
		assert (lat >= resp_timeout)
		else abort_run($sformatf("[ERROR] timeout latency = 0x%0h, expected at least 0x%0h",
			lat, resp_timeout));
		@(posedge rxoutclk);
		stay_silent <= 1'b0;

		// Alignment loss and recovery
		@(posedge rxoutclk);
		drop_align <= 1'b1;
		@(negedge rxoutclk);
		start = cycle;
		while (link_up) @(negedge rxoutclk);
		assert (cycle - start <= 2)
		else abort_run($sformatf("[ERROR] link_up fell 0x%0h cycles after the drop", cycle - start));
		apb_transfer(1'b1, 10'h3ff, 32'h12345678, rdata, err, lat);
		expect_result(1'b1, st_link_down);
		@(posedge rxoutclk);
		drop_align <= 1'b0;
		@(negedge rxoutclk);
		start = cycle;
		do @(negedge rxoutclk); while (!link_up);
		assert (cycle - start >= idle_run && cycle - start <= idle_run + 4)
		else abort_run($sformatf("[ERROR] link_up came back after 0x%0h cycles", cycle - start));
		wdata = $random(seed);
		apb_transfer(1'b1, 10'h3ff, wdata, rdata, err, lat);
		expected_frames++;
		expect_result(1'b0, st_ok);
		apb_transfer(1'b0, 10'h3ff, '0, rdata, err, lat);
		expected_frames++;
		expect_result(1'b0, st_ok);
		check_value("prdata", rdata, wdata);

		// Every launched request reached the far end once
		repeat (4) @(negedge rxoutclk);
		check_value("frames_seen", frames_seen, expected_frames);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* apb_link_bridge.f */
link_pkg.sv
apb_pkg.sv
link_monitor.sv
req_framer.sv
resp_deframer.sv
apb_completer.sv
apb_link_bridge.sv
tb_far_end.sv
apb_link_bridge_tb.sv

/* Makefile */
# Verilator build and run of the APB link bridge testbench

VERILATOR ?= verilator
TOP ?= apb_link_bridge_tb
FILELIST ?= apb_link_bridge.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := TEST RESULT: FAIL
PASS_MSG := TEST RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
